//--- logic/main_addr_decode.sv
`default_nettype none

module main_addr_decode
    import main_map_pkg::*;
#(
    parameter int ram_aw = 12
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mem_req,
    input  wire logic [cpu_aw-1:0] addr,
    input  wire logic              wr,
    input  wire logic [cpu_dw-1:0] wdata,
    output logic                   rom_cs,
    output logic                   vram_cs,
    output logic                   ram_cs,
    output logic                   vctrl_cs,
    output logic                   pal_cs,
    output logic                   bank_we,
    output dev_sel_e               dev_sel,
    output logic [cpu_aw-1:0]      cpu_addr,
    output logic [cpu_dw-1:0]      cpu_dout,
    output logic                   cpu_rnw,
    output logic [ram_aw-1:0]      ram_addr
);

    dev_sel_e sel_next;

    // Region hits on the raw request address
    logic in_rom;
    logic in_vram;
    logic in_ram;
    logic in_vctrl;
    logic in_bank;
    logic in_pal;

    assign in_rom   = addr <= rom_hi;
    assign in_vram  = addr >= vram_lo && addr <= vram_hi;
    assign in_ram   = addr >= ram_lo && addr <= ram_hi;
    assign in_vctrl = addr >= vctrl_lo && addr <= vctrl_hi;
    assign in_bank  = addr >= bank_lo && addr <= bank_hi;
    assign in_pal   = addr >= pal_lo && addr <= pal_hi;

    // Regions do not overlap, order only matters for readability
    always_comb begin
        sel_next = dev_none;
        if (mem_req) begin
            if (in_rom) begin
                sel_next = dev_rom;
            end else if (in_vram) begin
                sel_next = dev_vram;
            end else if (in_ram) begin
                sel_next = dev_ram;
            end else if (in_vctrl) begin
                sel_next = dev_vctrl;
            end else if (in_pal) begin
                sel_next = dev_pal;
            end else if (in_bank && wr) begin
                // Bank latch is write only
                sel_next = dev_bank;
            end
        end
    end

    // One-cycle selects, all from the same encoded choice
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dev_sel  <= dev_none;
            rom_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            ram_cs   <= 1'b0;
            vctrl_cs <= 1'b0;
            pal_cs   <= 1'b0;
            bank_we  <= 1'b0;
            cpu_rnw  <= 1'b0;
        end else begin
            dev_sel  <= sel_next;
            rom_cs   <= sel_next == dev_rom;
            vram_cs  <= sel_next == dev_vram;
            ram_cs   <= sel_next == dev_ram;
            vctrl_cs <= sel_next == dev_vctrl;
            pal_cs   <= sel_next == dev_pal;
            bank_we  <= sel_next == dev_bank;
            // High only in the cycle after a read request
            cpu_rnw  <= mem_req && !wr;
        end
    end

    // Request payload, held until the next request
    always_ff @(posedge clk) begin
        if (mem_req) begin
            cpu_addr <= addr;
            cpu_dout <= wdata;
        end
    end

    // Shared RAM sees the low bits of the held address
    assign ram_addr = cpu_addr[ram_aw-1:0];

endmodule

`default_nettype wire

//--- logic/main_cpu_bus.sv
`default_nettype none

module main_cpu_bus
    import main_map_pkg::*;
#(
    parameter int ram_aw = 12
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              lvbl,
    // Bus master
    input  wire logic              mem_req,
    input  wire logic              iorq,
    input  wire logic [cpu_aw-1:0] addr,
    input  wire logic              wr,
    input  wire logic [cpu_dw-1:0] wdata,
    output logic [cpu_dw-1:0]      rdata,
    output logic                   rd_valid,
    output logic                   int_n,
    // Program ROM
    output logic                   rom_cs,
    output logic [rom_aw-1:0]      rom_addr,
    input  wire logic [cpu_dw-1:0] rom_data,
    // Video devices
    output logic                   vram_cs,
    output logic                   vctrl_cs,
    output logic                   pal_cs,
    input  wire logic [cpu_dw-1:0] vram_dout,
    input  wire logic [cpu_dw-1:0] pal_dout,
    // Held request for external devices
    output logic [cpu_aw-1:0]      cpu_addr,
    output logic [cpu_dw-1:0]      cpu_dout,
    output logic                   cpu_rnw,
    // Sound CPU
    output logic                   snd_rstn,
    input  wire logic [ram_aw-1:0] shr_addr,
    input  wire logic [cpu_dw-1:0] shr_din,
    input  wire logic              shr_we,
    output logic [cpu_dw-1:0]      shr_dout
);

    logic              ram_cs;
    logic              bank_we;
    logic              ram_we;
    dev_sel_e          dev_sel;
    logic [ram_aw-1:0] ram_addr;
    logic [cpu_dw-1:0] ram_q;

    // Main side RAM write, lands at the end of the select cycle
    assign ram_we = ram_cs && !cpu_rnw;

    main_addr_decode #(
        .ram_aw   (ram_aw)
    ) u_decode (
        .clk      (clk),
        .rst      (rst),
        .mem_req  (mem_req),
        .addr     (addr),
        .wr       (wr),
        .wdata    (wdata),
        .rom_cs   (rom_cs),
        .vram_cs  (vram_cs),
        .ram_cs   (ram_cs),
        .vctrl_cs (vctrl_cs),
        .pal_cs   (pal_cs),
        .bank_we  (bank_we),
        .dev_sel  (dev_sel),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_rnw  (cpu_rnw),
        .ram_addr (ram_addr)
    );

    main_rom_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .bank_we  (bank_we),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .rom_addr (rom_addr),
        .snd_rstn (snd_rstn)
    );

    vblank_irq u_irq (
        .clk   (clk),
        .rst   (rst),
        .lvbl  (lvbl),
        .iorq  (iorq),
        .int_n (int_n)
    );

    // Communication RAM between both CPUs
    shared_ram #(
        .ram_aw     (ram_aw)
    ) u_shr (
        .clk        (clk),
        .main_addr  (ram_addr),
        .main_wdata (cpu_dout),
        .main_we    (ram_we),
        .main_q     (ram_q),
        .shr_addr   (shr_addr),
        .shr_din    (shr_din),
        .shr_we     (shr_we),
        .shr_dout   (shr_dout)
    );

    main_read_mux u_rmux (
        .clk       (clk),
        .rst       (rst),
        .dev_sel   (dev_sel),
        .cpu_rnw   (cpu_rnw),
        .rom_data  (rom_data),
        .vram_dout (vram_dout),
        .pal_dout  (pal_dout),
        .ram_q     (ram_q),
        .rdata     (rdata),
        .rd_valid  (rd_valid)
    );

endmodule

`default_nettype wire

//--- logic/main_ctrl_pkg.sv
`default_nettype none

package main_ctrl_pkg;

    // Bank latch layout, as written through F6xx

    // ROM page bits, 8 pages of 16 kB
    localparam int bank_w = 3;
    // Page field starts at data bit 0
    localparam int bank_lsb = 0;

    // Sound CPU reset, active low when the bit is clear
    localparam int snd_rst_bit = 4;

endpackage

`default_nettype wire

//--- logic/main_map_pkg.sv
`default_nettype none

package main_map_pkg;

    // Main CPU bus widths
    localparam int cpu_aw = 16;
    localparam int cpu_dw = 8;

    // Banked program ROM, 128 kB
    localparam int rom_aw = 17;

    // One value per decoded device
    // dev_none also covers unmapped space and bank reads
    typedef enum logic [2:0] {
        dev_none,
        dev_rom,
        dev_ram,
        dev_vram,
        dev_vctrl,
        dev_pal,
        dev_bank
    } dev_sel_e;

    // Region bounds, both ends inclusive
    // Fixed ROM plus banked window
    localparam logic [cpu_aw-1:0] rom_hi = 16'hbfff;
    // Tile and sprite RAM
    localparam logic [cpu_aw-1:0] vram_lo = 16'hc000;
    localparam logic [cpu_aw-1:0] vram_hi = 16'hdfff;
    // RAM shared with the sound CPU
    localparam logic [cpu_aw-1:0] ram_lo = 16'he000;
    localparam logic [cpu_aw-1:0] ram_hi = 16'hefff;
    // Video chip registers and internal RAM
    localparam logic [cpu_aw-1:0] vctrl_lo = 16'hf000;
    localparam logic [cpu_aw-1:0] vctrl_hi = 16'hf4ff;
    // Bank latch, decoded on writes only
    localparam logic [cpu_aw-1:0] bank_lo = 16'hf600;
    localparam logic [cpu_aw-1:0] bank_hi = 16'hf6ff;
    // Colour palette
    localparam logic [cpu_aw-1:0] pal_lo = 16'hf800;
    localparam logic [cpu_aw-1:0] pal_hi = 16'hfbff;

    // Start of the ROM area that follows the bank register
    localparam logic [cpu_aw-1:0] bank_win_lo = 16'h8000;

    // Pulled-up data bus when nothing drives it
    localparam logic [cpu_dw-1:0] open_bus_data = 8'hff;

endpackage

`default_nettype wire

//--- logic/main_read_mux.sv
`default_nettype none

module main_read_mux
    import main_map_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire dev_sel_e          dev_sel,
    input  wire logic              cpu_rnw,
    input  wire logic [cpu_dw-1:0] rom_data,
    input  wire logic [cpu_dw-1:0] vram_dout,
    input  wire logic [cpu_dw-1:0] pal_dout,
    input  wire logic [cpu_dw-1:0] ram_q,
    output logic [cpu_dw-1:0]      rdata,
    output logic                   rd_valid
);

    // Select and read flag, aligned with device data
    dev_sel_e          sel_d;
    logic              rd_d;
    logic [cpu_dw-1:0] src;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_d    <= dev_none;
            rd_d     <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            sel_d    <= dev_sel;
            rd_d     <= cpu_rnw;
            // Writes never return data
            rd_valid <= rd_d;
        end
    end

    // Video controller shares the video data bus
    always_comb begin
        case (sel_d)
            dev_rom:   src = rom_data;
            dev_ram:   src = ram_q;
            dev_vram:  src = vram_dout;
            dev_vctrl: src = vram_dout;
            dev_pal:   src = pal_dout;
            default:   src = open_bus_data;
        endcase
    end

    // Held until the next read completes
    always_ff @(posedge clk) begin
        if (rd_d) begin
            rdata <= src;
        end
    end

endmodule

`default_nettype wire

//--- logic/main_rom_bank.sv
`default_nettype none

module main_rom_bank
    import main_map_pkg::*;
    import main_ctrl_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              bank_we,
    input  wire logic [cpu_aw-1:0] cpu_addr,
    input  wire logic [cpu_dw-1:0] cpu_dout,
    output logic [rom_aw-1:0]      rom_addr,
    output logic                   snd_rstn
);

    // Page size follows from ROM width and bank width
    localparam int page_aw = rom_aw - bank_w;

    logic [bank_w-1:0] bank;
    logic              in_window;

    // Bank latch holds the sound CPU in reset until the first write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            snd_rstn <= 1'b0;
        end else if (bank_we) begin
            bank     <= cpu_dout[bank_lsb +: bank_w];
            snd_rstn <= cpu_dout[snd_rst_bit];
        end
    end

    // 8000-BFFF is paged
    assign in_window = cpu_addr >= bank_win_lo;

    // Below 8000 page 0 shows through
    always_comb begin
        rom_addr = {{bank_w{1'b0}}, cpu_addr[page_aw-1:0]};
        if (in_window) begin
            rom_addr[rom_aw-1:page_aw] = bank;
        end
    end

endmodule

`default_nettype wire

//--- logic/shared_ram.sv
`default_nettype none

module shared_ram
    import main_map_pkg::*;
#(
    parameter int ram_aw = 12
) (
    input  wire logic              clk,
    // Main CPU side
    input  wire logic [ram_aw-1:0] main_addr,
    input  wire logic [cpu_dw-1:0] main_wdata,
    input  wire logic              main_we,
    output logic [cpu_dw-1:0]      main_q,
    // Sound CPU side
    input  wire logic [ram_aw-1:0] shr_addr,
    input  wire logic [cpu_dw-1:0] shr_din,
    input  wire logic              shr_we,
    output logic [cpu_dw-1:0]      shr_dout
);

    logic [cpu_dw-1:0] mem [2**ram_aw];

    // Main port reads before it writes
    always @(posedge clk) begin
        if (main_we) begin
            mem[main_addr] <= main_wdata;
        end
        main_q <= mem[main_addr];
    end

    // Sound port behaves the same
    // same-address writes from both sides are left undefined
    always @(posedge clk) begin
        if (shr_we) begin
            mem[shr_addr] <= shr_din;
        end
        shr_dout <= mem[shr_addr];
    end

endmodule

`default_nettype wire

//--- logic/vblank_irq.sv
`default_nettype none

module vblank_irq (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic lvbl,
    input  wire logic iorq,
    output logic      int_n
);

    // Two stages so the edge is seen on registered values
    logic lvbl_q;
    logic lvbl_qq;
    logic lvbl_fall;

    // Reset low, no false edge if blanking at start-up
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_q  <= 1'b0;
            lvbl_qq <= 1'b0;
        end else begin
            lvbl_q  <= lvbl;
            lvbl_qq <= lvbl_q;
        end
    end

    assign lvbl_fall = lvbl_qq && !lvbl_q;

    // Interrupt latch, set wins over acknowledge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_n <= 1'b1;
        end else if (lvbl_fall) begin
            int_n <= 1'b0;
        end else if (iorq) begin
            int_n <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sim.f
logic/main_map_pkg.sv
logic/main_ctrl_pkg.sv
logic/main_addr_decode.sv
logic/main_rom_bank.sv
logic/vblank_irq.sv
logic/shared_ram.sv
logic/main_read_mux.sv
logic/main_cpu_bus.sv
sim/main_cpu_bus_assertions.sv
sim/main_cpu_bus_tb.sv

//--- sim/main_cpu_bus_assertions.sv
`default_nettype none

module main_cpu_bus_assertions (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       mem_req,
    input wire logic       wr,
    // rom, ram, vram, vctrl, pal, bank
    input wire logic [5:0] sel,
    input wire logic       rd_valid
);

    // Failures seen so far, polled by the testbench
    int err_count = 0;

    // Never two devices at once
    assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
        else begin
            err_count++;
            $error("more than one device select high");
        end

    // Each select comes from a request, one cycle per request
    assert property (@(posedge clk) disable iff (rst) |sel |-> $past(mem_req))
        else begin
            err_count++;
            $error("select without a request one cycle earlier");
        end

    // Read data three cycles after the request, and only then
    assert property (@(posedge clk) disable iff (rst) mem_req && !wr |-> ##3 rd_valid)
        else begin
            err_count++;
            $error("read request not answered three cycles later");
        end
    assert property (@(posedge clk) disable iff (rst) rd_valid |-> $past(mem_req && !wr, 3))
        else begin
            err_count++;
            $error("rd_valid without a read three cycles earlier");
        end

endmodule

bind main_cpu_bus main_cpu_bus_assertions u_assert (
    .clk      (clk),
    .rst      (rst),
    .mem_req  (mem_req),
    .wr       (wr),
    .sel      ({rom_cs, ram_cs, vram_cs, vctrl_cs, pal_cs, bank_we}),
    .rd_valid (rd_valid)
);

`default_nettype wire

//--- sim/main_cpu_bus_tb.sv
`default_nettype none

module main_cpu_bus_tb
    import main_map_pkg::*;
    import main_ctrl_pkg::*;
();

    localparam int ram_aw = 12;

    // Master operations in the stimulus table
    localparam logic [2:0] op_rd  = 3'd0;
    localparam logic [2:0] op_wr  = 3'd1;
    localparam logic [2:0] op_ack = 3'd2;
    localparam logic [2:0] op_vbl = 3'd3;
    localparam logic [2:0] op_snd = 3'd4;
    // Main side shared RAM write checked on the sound port
    localparam logic [2:0] op_rwr = 3'd5;

    typedef struct packed {
        logic [2:0]        op;
        logic [cpu_aw-1:0] addr;
        logic [cpu_dw-1:0] data;
        dev_sel_e          sel;
        logic [cpu_dw-1:0] rd;
    } step_t;

    logic              clk;
    logic              rst;
    logic              lvbl;
    // Bus master
    logic              mem_req;
    logic              iorq;
    logic              wr;
    logic [cpu_aw-1:0] addr;
    logic [cpu_dw-1:0] wdata;
    logic [cpu_dw-1:0] rdata;
    logic              rd_valid;
    logic              int_n;
    // External devices
    logic              rom_cs;
    logic              vram_cs;
    logic              vctrl_cs;
    logic              pal_cs;
    logic [rom_aw-1:0] rom_addr;
    logic [cpu_dw-1:0] rom_data;
    logic [cpu_dw-1:0] vram_dout;
    logic [cpu_dw-1:0] pal_dout;
    logic [cpu_aw-1:0] cpu_addr;
    logic [cpu_dw-1:0] cpu_dout;
    logic              cpu_rnw;
    // Sound CPU port
    logic              snd_rstn;
    logic              shr_we;
    logic [ram_aw-1:0] shr_addr;
    logic [cpu_dw-1:0] shr_din;
    logic [cpu_dw-1:0] shr_dout;

    step_t             steps[$];
    step_t             s;
    // Expected read data with the oldest first
    logic [cpu_dw-1:0] exp_q[$];
    logic [cpu_dw-1:0] b;
    logic [31:0]       lfsr;
    // Page the DUT should be on
    logic [bank_w-1:0] tb_bank;
    int                cycles;
    int                limit;
    int                n;

    main_cpu_bus #(.ram_aw(ram_aw)) dut (.*);

    always #10 clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] v);
        return v[0] ? (v >> 1) ^ 32'h8020_0003 : v >> 1;
    endfunction

    // One step per data bit
    task automatic rand_byte(output logic [cpu_dw-1:0] r);
        for (int i = 0; i < cpu_dw; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
    endtask

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
            fail_run("value check failed");
        end
    endtask

    function automatic void add_step(input logic [2:0] op, input logic [cpu_aw-1:0] a,
                                     input logic [cpu_dw-1:0] d, input dev_sel_e sel,
                                     input logic [cpu_dw-1:0] rd);
        steps.push_back(step_t'{op, a, d, sel, rd});
    endfunction

    // Drive one request and check its select cycle
    task automatic issue_req(input step_t st, input logic is_wr, input logic [cpu_dw-1:0] d);
        logic [5:0]        want_cs;
        logic [rom_aw-1:0] want_rom;
        // Select vector in enum order from rom down to bank
        want_cs  = (st.sel == dev_none) ? 6'd0 : 6'b100000 >> (st.sel - 1);
        // Page bits follow the bank only when address bit 15 is set
        want_rom = {(st.addr[cpu_aw-1] ? tb_bank : {bank_w{1'b0}}),
                    st.addr[rom_aw-bank_w-1:0]};
        mem_req = 1'b1;
        addr    = st.addr;
        wr      = is_wr;
        wdata   = d;
        @(negedge clk);
        mem_req = 1'b0;
        wr      = 1'b0;
        check_val("selects", {rom_cs, dut.ram_cs, vram_cs, vctrl_cs, pal_cs, dut.bank_we},
                  want_cs);
        check_val("cpu_addr", cpu_addr, st.addr);
        check_val("cpu_rnw", cpu_rnw, !is_wr);
        if (is_wr) begin
            check_val("cpu_dout", cpu_dout, d);
        end
        if (st.sel == dev_rom) begin
            check_val("rom_addr", rom_addr, want_rom);
        end
    endtask

    // ROM, video and palette answer one cycle after their select
    always @(posedge clk) begin
        if (rom_cs) begin
            rom_data <= rom_addr[7:0] ^ {5'd0, rom_addr[rom_aw-1 -: bank_w]};
        end
        if (vram_cs || vctrl_cs) begin
            vram_dout <= cpu_addr[7:0] ^ 8'h5a;
        end
        if (pal_cs) begin
            pal_dout <= cpu_addr[7:0] ^ 8'ha5;
        end
    end

    // Read returns come back in request order
    always @(negedge clk) begin
        if (dut.u_assert.err_count != 0) begin
            fail_run("a bound bus assertion failed");
        end else if (!rst && rd_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("rd_valid pulsed with no read outstanding");
            end else begin
                check_val("rdata", rdata, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            fail_run("run did not finish within the cycle limit");
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        lvbl      = 1'b1;
        mem_req   = 1'b0;
        iorq      = 1'b0;
        wr        = 1'b0;
        addr      = '0;
        wdata     = '0;
        rom_data  = '0;
        vram_dout = '0;
        pal_dout  = '0;
        shr_we    = 1'b0;
        shr_addr  = '0;
        shr_din   = '0;
        lfsr      = 32'h4aa0;
        tb_bank   = '0;
        cycles    = 0;

        // Decode and read return issued back to back
        add_step(op_rd,  16'h1234, 8'h00, dev_rom,   8'h34);
        add_step(op_rd,  16'hc012, 8'h00, dev_vram,  8'h48);
        add_step(op_rd,  16'hf123, 8'h00, dev_vctrl, 8'h79);
        add_step(op_rd,  16'h9abc, 8'h00, dev_rom,   8'hbc);
        add_step(op_rd,  16'hf9c3, 8'h00, dev_pal,   8'h66);
        add_step(op_rd,  16'hd0ff, 8'h00, dev_vram,  8'ha5);
        // Unmapped space and bank reads float high
        add_step(op_rd,  16'hf580, 8'h00, dev_none,  8'hff);
        add_step(op_rd,  16'hf640, 8'h00, dev_none,  8'hff);
        add_step(op_rd,  16'hfe00, 8'h00, dev_none,  8'hff);
        add_step(op_wr,  16'hfc00, 8'h3c, dev_none,  8'h00);
        // Page 5 with the sound CPU released
        add_step(op_wr,  16'hf615, 8'h15, dev_bank,  8'h00);
        add_step(op_rd,  16'ha001, 8'h00, dev_rom,   8'h04);
        add_step(op_rd,  16'h4321, 8'h00, dev_rom,   8'h21);
        add_step(op_rd,  16'hbfff, 8'h00, dev_rom,   8'hfa);
        // Page 3 with the sound CPU held again
        add_step(op_wr,  16'hf603, 8'h03, dev_bank,  8'h00);
        add_step(op_rd,  16'h8080, 8'h00, dev_rom,   8'h83);
        add_step(op_wr,  16'hc100, 8'h77, dev_vram,  8'h00);
        add_step(op_wr,  16'hf800, 8'h12, dev_pal,   8'h00);
        // Shared RAM from both sides
        add_step(op_rwr, 16'he123, 8'h00, dev_ram,   8'h00);
        add_step(op_rwr, 16'hefff, 8'h00, dev_ram,   8'h00);
        add_step(op_snd, 16'he456, 8'h00, dev_ram,   8'h00);
        add_step(op_snd, 16'he000, 8'h00, dev_ram,   8'h00);
        // Two vblank rounds
        add_step(op_vbl, 16'h0000, 8'h00, dev_none,  8'h00);
        add_step(op_ack, 16'h0000, 8'h00, dev_none,  8'h00);
        add_step(op_vbl, 16'h0000, 8'h00, dev_none,  8'h00);
        add_step(op_ack, 16'h0000, 8'h00, dev_none,  8'h00);

        limit = steps.size() * 8 + 100;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_val("int_n", int_n, 1'b1);
        check_val("snd_rstn", snd_rstn, 1'b0);

        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                op_rd: begin
                    exp_q.push_back(s.rd);
                    issue_req(s, 1'b0, '0);
                end
                op_wr: begin
                    issue_req(s, 1'b1, s.data);
                    if (s.sel == dev_bank) begin
                        tb_bank = s.data[bank_lsb +: bank_w];
                        @(negedge clk);
                        check_val("snd_rstn", snd_rstn, s.data[snd_rst_bit]);
                    end
                end
                op_rwr: begin
                    rand_byte(b);
                    issue_req(s, 1'b1, b);
                    // Array written at the end of the select cycle
                    @(negedge clk);
                    shr_addr = s.addr[ram_aw-1:0];
                    @(negedge clk);
                    check_val("shr_dout", shr_dout, b);
                end
                op_snd: begin
                    rand_byte(b);
                    shr_addr = s.addr[ram_aw-1:0];
                    shr_din  = b;
                    shr_we   = 1'b1;
                    @(negedge clk);
                    shr_we = 1'b0;
                    exp_q.push_back(b);
                    issue_req(s, 1'b0, '0);
                end
                op_vbl: begin
                    lvbl = 1'b0;
                    n = 0;
                    while (int_n && n < 8) begin
                        @(negedge clk);
                        n++;
                    end
                    if (int_n) begin
                        fail_run("int_n stayed high after lvbl fell");
                    end
                end
                op_ack: begin
                    iorq = 1'b1;
                    @(negedge clk);
                    iorq = 1'b0;
                    check_val("int_n", int_n, 1'b1);
                    // Quiet while lvbl stays low and after it rises
                    repeat (2) begin
                        @(negedge clk);
                        check_val("int_n", int_n, 1'b1);
                    end
                    lvbl = 1'b1;
                    repeat (3) begin
                        @(negedge clk);
                        check_val("int_n", int_n, 1'b1);
                    end
                end
                default: fail_run("unknown operation in the stimulus table");
            endcase
        end

        // Let the last reads drain
        n = 0;
        while (exp_q.size() != 0 && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            fail_run("rd_valid never came for an outstanding read");
        end else begin
            repeat (4) @(negedge clk);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
